//--- map_switch_pkg.sv
`default_nettype none

package map_switch_pkg;

    typedef logic [9:0]  key_vec_t;
    typedef logic [2:0]  level_t;
    typedef logic [9:0]  screen_coord_t;
    typedef logic [16:0] pixel_addr_t;
    typedef logic [15:0] cover_addr_t;

    typedef enum logic [1:0] {
        MODE_COVER,
        MODE_MENU,
        MODE_PLAY
    } screen_mode_t;

    typedef enum logic [1:0] {
        FACE_STAND,
        FACE_RIGHT,
        FACE_LEFT,
        FACE_UP
    } facing_t;

    typedef enum logic [1:0] {
        JUMP_IDLE,
        JUMP_RISE,
        JUMP_FALL
    } jump_phase_t;

    // bit positions in key_down
    localparam int KEY_P2_JUMP       = 0;
    localparam int KEY_P2_LEFT       = 1;
    localparam int KEY_MENU_DOWN_ALT = 2;
    localparam int KEY_P2_RIGHT      = 3;
    localparam int KEY_P1_JUMP       = 4;
    localparam int KEY_P1_LEFT       = 5;
    localparam int KEY_MENU_DOWN     = 6;
    localparam int KEY_P1_RIGHT      = 7;
    localparam int KEY_CONFIRM       = 8;
    localparam int KEY_BACK          = 9;
    // menu up shares the jump keys
    localparam int KEY_MENU_UP       = KEY_P1_JUMP;
    localparam int KEY_MENU_UP_ALT   = KEY_P2_JUMP;

    localparam level_t LEVEL_MIN = 3'd1;
    localparam level_t LEVEL_MAX = 3'd5;

    // menu layout in half-resolution pixels
    localparam int MENU_ROW_TOP    = 40;
    localparam int MENU_ROW_PITCH  = 40;
    localparam int MENU_ROW_HEIGHT = 25;
    localparam int ICON_X0         = 150;
    localparam int ICON_X_MARK     = 148;
    localparam int ICON_X1         = 170;
    localparam int MARK_SRC_X      = 127;
    localparam int FB_STRIDE       = 320;

    // jump limits in clock cycles
    localparam int RISE_TICKS_DEF = 70_000_000;
    localparam int FALL_TICKS_DEF = 240_000_000;

endpackage

`default_nettype wire

//--- stage_select.sv
`timescale 1ns/1ps
`default_nettype none

module stage_select import map_switch_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  key_vec_t     key_down,
    input  logic         been_ready,
    output screen_mode_t mode,
    output level_t       level
);

    logic key_armed;
    logic key_idle;
    logic menu_up;
    logic menu_down;
    logic leave_play;

    assign key_idle   = (key_down == '0);
    assign menu_up    = key_down[KEY_MENU_UP] || key_down[KEY_MENU_UP_ALT];
    assign menu_down  = key_down[KEY_MENU_DOWN] || key_down[KEY_MENU_DOWN_ALT];
    assign leave_play = (key_down[KEY_CONFIRM] || key_down[KEY_BACK]) && been_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode      <= MODE_COVER;
            level     <= LEVEL_MIN;
            key_armed <= 1'b1;
        end else if (mode == MODE_PLAY) begin
            // back to menu ignores the re-arm
            if (leave_play) begin
                mode      <= MODE_MENU;
                key_armed <= 1'b0;
            end else if (key_idle) begin
                key_armed <= 1'b1;
            end
        end else if (key_idle) begin
            key_armed <= 1'b1;
        end else if (key_armed) begin
            if (menu_up) begin
                if (level != LEVEL_MAX) begin
                    level <= level + level_t'(1);
                end
                key_armed <= 1'b0;
            end else if (menu_down) begin
                if (level != LEVEL_MIN) begin
                    level <= level - level_t'(1);
                end
                key_armed <= 1'b0;
            end else if (key_down[KEY_CONFIRM]) begin
                // cover goes to menu, menu starts the level
                if (mode == MODE_COVER) begin
                    mode <= MODE_MENU;
                end else begin
                    mode <= MODE_PLAY;
                end
                key_armed <= 1'b0;
            end
        end
    end

    // cursor saturates at both ends
    level_in_range_a : assert property (
        @(posedge clk) disable iff (rst)
        (level >= LEVEL_MIN) && (level <= LEVEL_MAX)
    ) else $error("level %0d out of range", level);

    // level frozen while a level is running
    level_frozen_in_play_a : assert property (
        @(posedge clk) disable iff (rst)
        (mode == MODE_PLAY) |=> $stable(level)
    ) else $error("level changed during play");

endmodule

`default_nettype wire

//--- player_motion.sv
`timescale 1ns/1ps
`default_nettype none

module player_motion import map_switch_pkg::*; #(
    parameter int RISE_TICKS = RISE_TICKS_DEF,
    parameter int FALL_TICKS = FALL_TICKS_DEF
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         in_play,
    input  logic        jump_key,
    input  logic        left_key,
    input  logic        right_key,
    input  logic        collision,
    input  logic        land,
    input  logic        should_fall,
    output facing_t     facing,
    output jump_phase_t jump_phase
);

    localparam int CNT_W = $clog2(FALL_TICKS + 1);

    typedef logic [CNT_W-1:0] jump_cnt_t;

    localparam jump_cnt_t RISE_LIM = jump_cnt_t'(RISE_TICKS);
    localparam jump_cnt_t FALL_LIM = jump_cnt_t'(FALL_TICKS);

    jump_cnt_t   jump_cnt;
    jump_cnt_t   jump_cnt_nxt;
    facing_t     facing_nxt;
    jump_phase_t phase_nxt;

    // outcome of a full jump step and of its fall part alone
    jump_phase_t step_phase;
    jump_cnt_t   step_cnt;
    jump_phase_t fall_phase;
    jump_cnt_t   fall_cnt;

    always_comb begin
        if (jump_cnt < FALL_LIM && !land) begin
            fall_phase = JUMP_FALL;
            fall_cnt   = jump_cnt + jump_cnt_t'(1);
        end else begin
            fall_phase = JUMP_IDLE;
            fall_cnt   = '0;
        end

        // rise ends early on a collision
        if (jump_cnt < RISE_LIM && !collision && jump_phase != JUMP_FALL) begin
            step_phase = JUMP_RISE;
            step_cnt   = jump_cnt + jump_cnt_t'(1);
        end else begin
            step_phase = fall_phase;
            step_cnt   = fall_cnt;
        end
    end

    always_comb begin
        facing_nxt   = facing;
        phase_nxt    = jump_phase;
        jump_cnt_nxt = jump_cnt;

        if (!in_play) begin
            facing_nxt   = FACE_STAND;
            phase_nxt    = JUMP_IDLE;
            jump_cnt_nxt = '0;
        end else if (jump_key && !left_key && !right_key) begin
            facing_nxt   = FACE_UP;
            phase_nxt    = step_phase;
            jump_cnt_nxt = step_cnt;
        end else if (left_key != right_key) begin
            facing_nxt = left_key ? FACE_LEFT : FACE_RIGHT;
            if ((jump_key || jump_phase != JUMP_IDLE) && !should_fall) begin
                phase_nxt    = step_phase;
                jump_cnt_nxt = step_cnt;
            end else if (should_fall) begin
                // walked off an edge
                phase_nxt    = fall_phase;
                jump_cnt_nxt = fall_cnt;
            end else begin
                phase_nxt    = JUMP_IDLE;
                jump_cnt_nxt = '0;
            end
        end else if (!jump_key && !left_key && !right_key && jump_phase == JUMP_IDLE) begin
            facing_nxt = FACE_STAND;
        end else if (jump_phase != JUMP_IDLE) begin
            // jump finishes in the air on no key or both sides
            phase_nxt    = step_phase;
            jump_cnt_nxt = step_cnt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            facing     <= FACE_STAND;
            jump_phase <= JUMP_IDLE;
            jump_cnt   <= '0;
        end else begin
            facing     <= facing_nxt;
            jump_phase <= phase_nxt;
            jump_cnt   <= jump_cnt_nxt;
        end
    end

    // leaving play drops the player back to the ground
    idle_out_of_play_a : assert property (
        @(posedge clk) disable iff (rst)
        !in_play |=> (jump_phase == JUMP_IDLE)
    ) else $error("jump phase active outside play");

endmodule

`default_nettype wire

//--- screen_addr_select.sv
`timescale 1ns/1ps
`default_nettype none

module screen_addr_select import map_switch_pkg::*; (
    input  screen_mode_t  mode,
    input  level_t        level,
    input  screen_coord_t vga_h,
    input  screen_coord_t vga_v,
    input  cover_addr_t   cover_addr,
    input  pixel_addr_t   game_addr,
    output pixel_addr_t   pixel_addr
);

    localparam int NUM_ROWS = LEVEL_MAX;

    pixel_addr_t h;
    pixel_addr_t v;
    pixel_addr_t row_top;
    pixel_addr_t row_line;
    pixel_addr_t menu_addr;

    // menu is drawn at half resolution
    assign h = pixel_addr_t'(vga_h >> 1);
    assign v = pixel_addr_t'(vga_v >> 1);

    always_comb begin
        menu_addr = '0;
        row_top   = '0;
        row_line  = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row_top = pixel_addr_t'(MENU_ROW_TOP + MENU_ROW_PITCH * r);
            if (v >= row_top && v < row_top + pixel_addr_t'(MENU_ROW_HEIGHT)) begin
                // source lines start one above the row top
                row_line = v - row_top + pixel_addr_t'(1);
                if (level == level_t'(r + 1)) begin
                    // chosen level uses the wider marked icon
                    if (h >= pixel_addr_t'(ICON_X_MARK) && h < pixel_addr_t'(ICON_X1)) begin
                        menu_addr = h - pixel_addr_t'(MARK_SRC_X)
                                    + row_line * pixel_addr_t'(FB_STRIDE);
                    end
                end else if (h >= pixel_addr_t'(ICON_X0) && h < pixel_addr_t'(ICON_X1)) begin
                    menu_addr = h - pixel_addr_t'(ICON_X0)
                                + row_line * pixel_addr_t'(FB_STRIDE);
                end
            end
        end
    end

    always_comb begin
        case (mode)
            MODE_COVER: pixel_addr = {1'b0, cover_addr};
            MODE_MENU:  pixel_addr = menu_addr;
            default:    pixel_addr = game_addr;
        endcase
    end

endmodule

`default_nettype wire

//--- map_switch.sv
`timescale 1ns/1ps
`default_nettype none

module map_switch import map_switch_pkg::*; #(
    parameter int RISE_TICKS = RISE_TICKS_DEF,
    parameter int FALL_TICKS = FALL_TICKS_DEF
) (
    input  wire           clk,
    input  wire           rst,
    input  key_vec_t      key_down,
    input  logic          been_ready,
    input  screen_coord_t vga_h,
    input  screen_coord_t vga_v,
    input  cover_addr_t   cover_addr,
    input  pixel_addr_t   game_addr,
    input  logic          p1_collision,
    input  logic          p2_collision,
    input  logic          p1_land,
    input  logic          p2_land,
    input  logic          p1_should_fall,
    input  logic          p2_should_fall,
    output pixel_addr_t   pixel_addr,
    output screen_mode_t  mode,
    output level_t        level,
    output facing_t       p1_facing,
    output facing_t       p2_facing,
    output jump_phase_t   p1_jump_phase,
    output jump_phase_t   p2_jump_phase
);

    stage_select stage_select_i (
        .clk        (clk),
        .rst        (rst),
        .key_down   (key_down),
        .been_ready (been_ready),
        .mode       (mode),
        .level      (level)
    );

    player_motion #(
        .RISE_TICKS (RISE_TICKS),
        .FALL_TICKS (FALL_TICKS)
    ) p1_motion_i (
        .clk         (clk),
        .rst         (rst),
        .in_play     (mode == MODE_PLAY),
        .jump_key    (key_down[KEY_P1_JUMP]),
        .left_key    (key_down[KEY_P1_LEFT]),
        .right_key   (key_down[KEY_P1_RIGHT]),
        .collision   (p1_collision),
        .land        (p1_land),
        .should_fall (p1_should_fall),
        .facing      (p1_facing),
        .jump_phase  (p1_jump_phase)
    );

    player_motion #(
        .RISE_TICKS (RISE_TICKS),
        .FALL_TICKS (FALL_TICKS)
    ) p2_motion_i (
        .clk         (clk),
        .rst         (rst),
        .in_play     (mode == MODE_PLAY),
        .jump_key    (key_down[KEY_P2_JUMP]),
        .left_key    (key_down[KEY_P2_LEFT]),
        .right_key   (key_down[KEY_P2_RIGHT]),
        .collision   (p2_collision),
        .land        (p2_land),
        .should_fall (p2_should_fall),
        .facing      (p2_facing),
        .jump_phase  (p2_jump_phase)
    );

    screen_addr_select screen_addr_select_i (
        .mode       (mode),
        .level      (level),
        .vga_h      (vga_h),
        .vga_v      (vga_v),
        .cover_addr (cover_addr),
        .game_addr  (game_addr),
        .pixel_addr (pixel_addr)
    );

endmodule

`default_nettype wire

//--- tb_map_switch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_map_switch import map_switch_pkg::*; ();

    localparam int RISE = 6;
    localparam int FALL = 20;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic          clk;
    logic          rst;
    key_vec_t      key_down;
    logic          been_ready;
    screen_coord_t vga_h;
    screen_coord_t vga_v;
    cover_addr_t   cover_addr;
    pixel_addr_t   game_addr;
    logic          p1_collision;
    logic          p2_collision;
    logic          p1_land;
    logic          p2_land;
    logic          p1_should_fall;
    logic          p2_should_fall;
    pixel_addr_t   pixel_addr;
    screen_mode_t  mode;
    level_t        level;
    facing_t       p1_facing;
    facing_t       p2_facing;
    jump_phase_t   p1_jump_phase;
    jump_phase_t   p2_jump_phase;

    logic [31:0] lfsr;
    int          errors;
    int          test_errs;
    int          tests;
    int          tests_failed;

    map_switch #(
        .RISE_TICKS (RISE),
        .FALL_TICKS (FALL)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .key_down       (key_down),
        .been_ready     (been_ready),
        .vga_h          (vga_h),
        .vga_v          (vga_v),
        .cover_addr     (cover_addr),
        .game_addr      (game_addr),
        .p1_collision   (p1_collision),
        .p2_collision   (p2_collision),
        .p1_land        (p1_land),
        .p2_land        (p2_land),
        .p1_should_fall (p1_should_fall),
        .p2_should_fall (p2_should_fall),
        .pixel_addr     (pixel_addr),
        .mode           (mode),
        .level          (level),
        .p1_facing      (p1_facing),
        .p2_facing      (p2_facing),
        .p1_jump_phase  (p1_jump_phase),
        .p2_jump_phase  (p2_jump_phase)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one lfsr step per bit
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int face_of(input int p);
        return (p == 1) ? int'(p1_facing) : int'(p2_facing);
    endfunction

    function automatic int phase_of(input int p);
        return (p == 1) ? int'(p1_jump_phase) : int'(p2_jump_phase);
    endfunction

    // icon rows and the marked icon of the chosen level
    function automatic int menu_model(input int lvl, input int hc, input int vc);
        int h;
        int v;
        int top;
        int res;
        h   = hc / 2;
        v   = vc / 2;
        res = 0;
        for (int r = 0; r < 5; r++) begin
            top = 40 + 40 * r;
            if (v >= top && v <= top + 24) begin
                if (r == lvl - 1) begin
                    if (h >= 148 && h <= 169) begin
                        res = (h - 127) + (v - 39 - 40 * r) * 320;
                    end
                end else if (h >= 150 && h <= 169) begin
                    res = (h - 150) + (v - 39 - 40 * r) * 320;
                end
            end
        end
        return res;
    endfunction

    task automatic check_eq(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errs);
            tests_failed++;
        end
        errors += test_errs;
        test_errs = 0;
    endtask

    task automatic sample_edge();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_mode(input screen_mode_t m, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (mode != m && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (mode != m) begin
            $display("timeout waiting for mode %s", m.name());
            $display("*** FAILED ***");
            $finish;
        end
    endtask

    task automatic wait_phase(input int p, input jump_phase_t ph, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (phase_of(p) != int'(ph) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (phase_of(p) != int'(ph)) begin
            $display("timeout waiting for player %0d phase %s", p, ph.name());
            $display("*** FAILED ***");
            $finish;
        end
    endtask

    // one-cycle press then one-cycle release
    task automatic press_key(input int k);
        @(posedge clk);
        key_down <= key_vec_t'(1) << k;
        @(posedge clk);
        key_down <= '0;
        sample_edge();
    endtask

    task automatic drive_player(input int p, input int j, input int l, input int r,
                                input int c, input int ld, input int sf);
        if (p == 1) begin
            key_down[KEY_P1_JUMP]  <= (j != 0);
            key_down[KEY_P1_LEFT]  <= (l != 0);
            key_down[KEY_P1_RIGHT] <= (r != 0);
            p1_collision           <= (c != 0);
            p1_land                <= (ld != 0);
            p1_should_fall         <= (sf != 0);
        end else begin
            key_down[KEY_P2_JUMP]  <= (j != 0);
            key_down[KEY_P2_LEFT]  <= (l != 0);
            key_down[KEY_P2_RIGHT] <= (r != 0);
            p2_collision           <= (c != 0);
            p2_land                <= (ld != 0);
            p2_should_fall         <= (sf != 0);
        end
    endtask

    task automatic jump_model(inout jump_phase_t ph, inout int cnt,
                              input logic c, input logic ld);
        if (cnt < RISE && !c && ph != JUMP_FALL) begin
            ph = JUMP_RISE;
            cnt++;
        end else if (cnt < FALL && !ld) begin
            ph = JUMP_FALL;
            cnt++;
        end else begin
            ph  = JUMP_IDLE;
            cnt = 0;
        end
    endtask

    // jump key held alone until the model lands
    task automatic run_jump(input int p, input int coll_edge, input int land_edge,
                            input int exp_edges);
        jump_phase_t ph;
        int          cnt;
        int          i;
        bit          done;
        ph   = JUMP_IDLE;
        cnt  = 0;
        i    = 0;
        done = 1'b0;
        @(posedge clk);
        drive_player(p, 1, 0, 0, int'(coll_edge == 1), int'(land_edge == 1), 0);
        while (!done && i < 60) begin
            i++;
            @(posedge clk);
            jump_model(ph, cnt, i == coll_edge, i == land_edge);
            if (ph == JUMP_IDLE) begin
                done = 1'b1;
                drive_player(p, 0, 0, 0, 0, 0, 0);
            end else begin
                drive_player(p, 1, 0, 0, int'(i + 1 == coll_edge), int'(i + 1 == land_edge), 0);
            end
            @(negedge clk);
            check_eq("facing", face_of(p), int'(FACE_UP));
            check_eq("jump_phase", phase_of(p), int'(ph));
        end
        if (!done) begin
            $display("timeout: player %0d jump never ended", p);
            $display("*** FAILED ***");
            $finish;
        end
        check_eq("jump edges", i, exp_edges);
        sample_edge();
        check_eq("facing", face_of(p), int'(FACE_STAND));
    endtask

    task automatic reset_test();
        @(negedge clk);
        check_eq("mode", int'(mode), int'(MODE_COVER));
        check_eq("level", int'(level), 1);
        for (int p = 1; p <= 2; p++) begin
            check_eq("facing", face_of(p), int'(FACE_STAND));
            check_eq("jump_phase", phase_of(p), int'(JUMP_IDLE));
        end
        check_eq("pixel_addr", int'(pixel_addr), int'(cover_addr));
        end_test("reset and cover");
    endtask

    task automatic menu_nav_test();
        int exp;
        exp = 1;
        press_key(KEY_CONFIRM);
        wait_mode(MODE_MENU, 4);
        for (int n = 0; n < 6; n++) begin
            press_key((n % 2 == 0) ? KEY_MENU_UP : KEY_MENU_UP_ALT);
            exp = (exp < 5) ? exp + 1 : 5;
            check_eq("level", int'(level), exp);
        end
        for (int n = 0; n < 6; n++) begin
            press_key((n % 2 == 0) ? KEY_MENU_DOWN : KEY_MENU_DOWN_ALT);
            exp = (exp > 1) ? exp - 1 : 1;
            check_eq("level", int'(level), exp);
        end
        // held key counts once
        @(posedge clk);
        key_down <= key_vec_t'(1) << KEY_MENU_UP;
        repeat (5) @(posedge clk);
        key_down <= '0;
        sample_edge();
        check_eq("level", int'(level), 2);
        press_key(KEY_MENU_DOWN);
        check_eq("level", int'(level), 1);
        end_test("menu navigation");
    endtask

    task automatic menu_addr_test();
        int hc;
        int vc;
        for (int lvl = 1; lvl <= 5; lvl++) begin
            if (lvl > 1) begin
                press_key(KEY_MENU_UP);
            end
            check_eq("level", int'(level), lvl);
            for (int n = 0; n < 40; n++) begin
                hc = 2 * (140 + take_bits(5)) + take_bits(1);
                vc = 2 * (30 + take_bits(8)) + take_bits(1);
                @(posedge clk);
                vga_h <= screen_coord_t'(hc);
                vga_v <= screen_coord_t'(vc);
                @(negedge clk);
                check_eq("pixel_addr", int'(pixel_addr), menu_model(lvl, hc, vc));
            end
        end
        end_test("menu addressing");
    endtask

    task automatic play_return_test();
        press_key(KEY_CONFIRM);
        wait_mode(MODE_PLAY, 4);
        @(posedge clk);
        game_addr <= pixel_addr_t'(take_bits(17));
        @(negedge clk);
        check_eq("pixel_addr", int'(pixel_addr), int'(game_addr));
        // leave both players busy
        @(posedge clk);
        key_down <= (key_vec_t'(1) << KEY_P1_JUMP) | (key_vec_t'(1) << KEY_P2_LEFT);
        sample_edge();
        check_eq("p1_jump_phase", int'(p1_jump_phase), int'(JUMP_RISE));
        check_eq("p2_facing", int'(p2_facing), int'(FACE_LEFT));
        @(posedge clk);
        key_down <= (key_vec_t'(1) << KEY_BACK) | (key_vec_t'(1) << KEY_P1_JUMP)
                    | (key_vec_t'(1) << KEY_P2_LEFT);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_eq("mode", int'(mode), int'(MODE_PLAY));
        @(posedge clk);
        been_ready <= 1'b1;
        wait_mode(MODE_MENU, 4);
        @(negedge clk);
        for (int p = 1; p <= 2; p++) begin
            check_eq("facing", face_of(p), int'(FACE_STAND));
            check_eq("jump_phase", phase_of(p), int'(JUMP_IDLE));
        end
        @(posedge clk);
        key_down   <= '0;
        been_ready <= 1'b0;
        sample_edge();
        end_test("play and return");
    endtask

    task automatic jump_timing_test();
        press_key(KEY_CONFIRM);
        wait_mode(MODE_PLAY, 4);
        run_jump(1, 0, 0, RISE + (FALL - RISE) + 1);
        run_jump(1, 3, 0, FALL + 1);
        run_jump(2, 0, 10, 10);
        end_test("jump timing");
    endtask

    task automatic facing_fall_test();
        for (int p = 1; p <= 2; p++) begin
            @(posedge clk);
            drive_player(p, 0, 1, 0, 0, 0, 0);
            sample_edge();
            check_eq("facing", face_of(p), int'(FACE_LEFT));
            check_eq("jump_phase", phase_of(p), int'(JUMP_IDLE));
            @(posedge clk);
            drive_player(p, 0, 0, 1, 0, 0, 0);
            sample_edge();
            check_eq("facing", face_of(p), int'(FACE_RIGHT));
            // walking off an edge
            @(posedge clk);
            drive_player(p, 0, 0, 1, 0, 0, 1);
            sample_edge();
            check_eq("jump_phase", phase_of(p), int'(JUMP_FALL));
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_eq("jump_phase", phase_of(p), int'(JUMP_FALL));
            @(posedge clk);
            drive_player(p, 0, 0, 1, 0, 1, 1);
            wait_phase(p, JUMP_IDLE, 4);
            check_eq("facing", face_of(p), int'(FACE_RIGHT));
            @(posedge clk);
            drive_player(p, 0, 0, 0, 0, 0, 0);
            sample_edge();
            check_eq("facing", face_of(p), int'(FACE_STAND));
        end
        end_test("facing and fall");
    endtask

    initial begin
        lfsr           = 32'd89797;
        errors         = 0;
        test_errs      = 0;
        tests          = 0;
        tests_failed   = 0;
        rst            = 1'b1;
        key_down       = '0;
        been_ready     = 1'b0;
        vga_h          = '0;
        vga_v          = '0;
        cover_addr     = 16'hbeef;
        game_addr      = '0;
        p1_collision   = 1'b0;
        p2_collision   = 1'b0;
        p1_land        = 1'b0;
        p2_land        = 1'b0;
        p1_should_fall = 1'b0;
        p2_should_fall = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_test();
        menu_nav_test();
        menu_addr_test();
        play_return_test();
        jump_timing_test();
        facing_fall_test();
        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- map_switch.f
map_switch_pkg.sv
stage_select.sv
player_motion.sv
screen_addr_select.sv
map_switch.sv
tb_map_switch.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_map_switch
RTL_TOP   := map_switch
FILELIST  := map_switch.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
